// ==== design/metric_gate.sv ====
`default_nettype none

module metric_gate #(
  parameter int AVG_WINDOW_LOG2 = 3
) (
  input  logic              clk,
  input  logic              i_arst_n,
  input  logic              i_stall,
  input  logic              i_valid,
  input  sync_pkg::metric_t i_metric,
  input  logic              i_last,
  output logic              o_valid,
  output sync_pkg::metric_t o_metric,
  output logic              o_last,
  output logic              o_gate
);

  localparam int WIN   = 1 << AVG_WINDOW_LOG2;
  localparam int SUM_W = sync_pkg::METRIC_WIDTH + AVG_WINDOW_LOG2;

  // Entry 0 is the newest metric of the current frame
  sync_pkg::metric_t win_q [WIN];
  logic [SUM_W-1:0]  sum_q;
  logic [SUM_W-1:0]  sum_next;
  logic [SUM_W-1:0]  thresh;
  logic              advance;
  logic              hit;

  assign advance = i_valid & ~i_stall;

  // Twice the window average, compared against history before this sample
  assign thresh = sum_q >> (AVG_WINDOW_LOG2 - 1);
  assign hit    = (SUM_W'(i_metric) >= thresh);

  assign sum_next = sum_q + SUM_W'(i_metric) - SUM_W'(win_q[WIN-1]);

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 0; i < WIN; i++) begin
        win_q[i] <= '0;
      end
      sum_q <= '0;
    end else if (advance) begin
      if (i_last) begin
        // A new frame starts with an empty history
        for (int i = 0; i < WIN; i++) begin
          win_q[i] <= '0;
        end
        sum_q <= '0;
      end else begin
        win_q[0] <= i_metric;
        for (int i = 1; i < WIN; i++) begin
          win_q[i] <= win_q[i-1];
        end
        sum_q <= sum_next;
      end
    end
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_valid <= 1'b0;
    end else if (!i_stall) begin
      o_valid <= i_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      o_metric <= i_metric;
      o_last   <= i_last;
      o_gate   <= hit;
    end
  end

endmodule

`default_nettype wire

// ==== design/out_credit_ctrl.sv ====
`default_nettype none

module out_credit_ctrl #(
  parameter int OUT_CREDITS = 4
) (
  input  logic clk,
  input  logic i_arst_n,
  input  logic i_valid,
  input  logic i_credit,
  output logic o_valid,
  output logic o_stall
);

  sync_pkg::credit_t credit_cnt;
  logic              has_credit;

  assign has_credit = (credit_cnt != '0);

  // A pending sample either leaves now or freezes the whole pipeline
  assign o_valid = i_valid & has_credit;
  assign o_stall = i_valid & ~has_credit;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      credit_cnt <= sync_pkg::credit_t'(OUT_CREDITS);
    end else if (o_valid && !i_credit) begin
      credit_cnt <= credit_cnt - 1'b1;
    end else if (i_credit && !o_valid) begin
      credit_cnt <= credit_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== design/peak_detect.sv ====
`default_nettype none

module peak_detect #(
  parameter int NRX_TRIG = 16
) (
  input  logic              clk,
  input  logic              i_arst_n,
  input  logic              i_stall,
  input  logic              i_valid,
  input  sync_pkg::metric_t i_metric,
  input  logic              i_last,
  input  logic              i_gate,
  output logic              o_valid,
  output sync_pkg::metric_t o_metric,
  output logic              o_last,
  output logic              o_gate,
  output logic              o_peak
);

  localparam int CNT_W = $clog2(NRX_TRIG + 1);

  sync_pkg::pk_state_e state_q;
  sync_pkg::pk_state_e state_d;
  sync_pkg::metric_t   max_q;
  sync_pkg::metric_t   max_d;
  sync_pkg::hist_t     hist_q;
  sync_pkg::hist_t     hist_d;
  logic [CNT_W-1:0]    hold_q;
  logic [CNT_W-1:0]    hold_d;
  logic                flag_q;
  logic                flag_d;
  logic                advance;

  assign advance = i_valid & ~i_stall;

  always_comb begin
    state_d = state_q;
    max_d   = max_q;
    hist_d  = hist_q;
    hold_d  = hold_q;
    flag_d  = flag_q;
    if (!i_gate) begin
      // Leaving the gated region restarts the search
      state_d = sync_pkg::PK_INIT;
      flag_d  = 1'b0;
    end else begin
      case (state_q)
        sync_pkg::PK_INIT: begin
          max_d   = i_metric;
          hist_d  = '0;
          hold_d  = '0;
          flag_d  = 1'b0;
          state_d = sync_pkg::PK_TRIG;
        end
        sync_pkg::PK_TRIG: begin
          if (hold_q >= CNT_W'(NRX_TRIG)) begin
            // Maximum has held long enough; flag only after eight rises
            hold_d  = '0;
            state_d = sync_pkg::PK_WAIT;
            flag_d  = &hist_q;
          end else if (i_metric == max_q) begin
            hold_d = '0;
          end else if (i_metric > max_q) begin
            max_d  = i_metric;
            hist_d = {hist_q[$bits(hist_q)-2:0], 1'b1};
            hold_d = '0;
          end else begin
            hold_d = hold_q + 1'b1;
          end
        end
        sync_pkg::PK_WAIT: begin
          state_d = sync_pkg::PK_IDLE;
        end
        sync_pkg::PK_IDLE: begin
          state_d = sync_pkg::PK_INIT;
        end
        default: begin
          state_d = sync_pkg::PK_INIT;
        end
      endcase
    end
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q <= sync_pkg::PK_INIT;
      max_q   <= '0;
      hist_q  <= '0;
      hold_q  <= '0;
      flag_q  <= 1'b0;
    end else if (advance) begin
      if (i_last) begin
        // Frame end wipes the detector after this sample is scored
        state_q <= sync_pkg::PK_INIT;
        max_q   <= '0;
        hist_q  <= '0;
        hold_q  <= '0;
        flag_q  <= 1'b0;
      end else begin
        state_q <= state_d;
        max_q   <= max_d;
        hist_q  <= hist_d;
        hold_q  <= hold_d;
        flag_q  <= flag_d;
      end
    end
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_valid <= 1'b0;
    end else if (!i_stall) begin
      o_valid <= i_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      o_metric <= i_metric;
      o_last   <= i_last;
      o_gate   <= i_gate;
      o_peak   <= flag_d;
    end
  end

endmodule

`default_nettype wire

// ==== design/sync_detect_top.sv ====
`default_nettype none

module sync_detect_top #(
  parameter int FIFO_DEPTH      = 8,
  parameter int AVG_WINDOW_LOG2 = 3,
  parameter int NRX_TRIG        = 16,
  parameter int OUT_CREDITS     = 4
) (
  input  logic              clk,
  input  logic              i_arst_n,
  input  logic              i_valid,
  input  sync_pkg::metric_t i_metric,
  input  logic              i_last,
  output logic              o_credit_return,
  output logic              o_valid,
  output sync_pkg::metric_t o_metric,
  output logic              o_last,
  output logic              o_gate,
  output logic              o_peak,
  input  logic              i_credit
);

  logic              fifo_valid;
  sync_pkg::metric_t fifo_metric;
  logic              fifo_last;

  logic              gate_valid;
  sync_pkg::metric_t gate_metric;
  logic              gate_last;
  logic              gate_hit;

  logic              pk_valid;
  sync_pkg::metric_t pk_metric;
  logic              pk_last;
  logic              pk_gate;
  logic              pk_peak;

  logic              stall;

  sync_in_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_in_fifo (
    .clk             (clk),
    .i_arst_n        (i_arst_n),
    .i_valid         (i_valid),
    .i_metric        (i_metric),
    .i_last          (i_last),
    .i_stall         (stall),
    .o_valid         (fifo_valid),
    .o_metric        (fifo_metric),
    .o_last          (fifo_last),
    .o_credit_return (o_credit_return)
  );

  metric_gate #(
    .AVG_WINDOW_LOG2 (AVG_WINDOW_LOG2)
  ) u_gate (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_stall  (stall),
    .i_valid  (fifo_valid),
    .i_metric (fifo_metric),
    .i_last   (fifo_last),
    .o_valid  (gate_valid),
    .o_metric (gate_metric),
    .o_last   (gate_last),
    .o_gate   (gate_hit)
  );

  peak_detect #(
    .NRX_TRIG (NRX_TRIG)
  ) u_peak (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_stall  (stall),
    .i_valid  (gate_valid),
    .i_metric (gate_metric),
    .i_last   (gate_last),
    .i_gate   (gate_hit),
    .o_valid  (pk_valid),
    .o_metric (pk_metric),
    .o_last   (pk_last),
    .o_gate   (pk_gate),
    .o_peak   (pk_peak)
  );

  // Payload comes straight from the detector stage and is qualified by o_valid
  assign o_metric = pk_metric;
  assign o_last   = pk_last;
  assign o_gate   = pk_gate;
  assign o_peak   = pk_peak;

  out_credit_ctrl #(
    .OUT_CREDITS (OUT_CREDITS)
  ) u_out_credit (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_valid  (pk_valid),
    .i_credit (i_credit),
    .o_valid  (o_valid),
    .o_stall  (stall)
  );

endmodule

`default_nettype wire

// ==== design/sync_in_fifo.sv ====
`default_nettype none

module sync_in_fifo #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic              clk,
  input  logic              i_arst_n,
  input  logic              i_valid,
  input  sync_pkg::metric_t i_metric,
  input  logic              i_last,
  input  logic              i_stall,
  output logic              o_valid,
  output sync_pkg::metric_t o_metric,
  output logic              o_last,
  output logic              o_credit_return
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  sync_pkg::metric_t mem_metric [FIFO_DEPTH];
  logic              mem_last   [FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             empty;
  logic             pop;
  logic             head_free;
  logic             take_mem;
  logic             bypass;
  logic             wr_en;

  assign full  = (count == CNT_W'(FIFO_DEPTH));
  assign empty = (count == '0);

  // The read stage is consumed on every cycle the pipeline is not stalled
  assign pop       = o_valid & ~i_stall;
  assign head_free = ~o_valid | pop;

  // An empty buffer lets a new sample go straight into the read stage
  assign take_mem = head_free & ~empty;
  assign bypass   = head_free & empty & i_valid;
  assign wr_en    = i_valid & ~bypass & ~full;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_ptr          <= '0;
      rd_ptr          <= '0;
      count           <= '0;
      o_valid         <= 1'b0;
      o_credit_return <= 1'b0;
    end else begin
      o_credit_return <= pop;
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (take_mem) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(wr_en) - CNT_W'(take_mem);
      if (head_free) begin
        o_valid <= take_mem | bypass;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem_metric[wr_ptr] <= i_metric;
      mem_last[wr_ptr]   <= i_last;
    end
    if (take_mem) begin
      o_metric <= mem_metric[rd_ptr];
      o_last   <= mem_last[rd_ptr];
    end else if (bypass) begin
      o_metric <= i_metric;
      o_last   <= i_last;
    end
  end

endmodule

`default_nettype wire

// ==== design/sync_pkg.sv ====
`default_nettype none

package sync_pkg;

  // Width of one correlation-metric sample
  parameter int METRIC_WIDTH = 16;

  typedef logic [METRIC_WIDTH-1:0] metric_t;

  // One bit is shifted in for every rise of the running maximum
  typedef logic [7:0] hist_t;

  typedef logic [7:0] credit_t;

  // Encodings follow the detector this block was derived from
  typedef enum logic [1:0] {
    PK_INIT = 2'b00,
    PK_WAIT = 2'b01,
    PK_TRIG = 2'b10,
    PK_IDLE = 2'b11
  } pk_state_e;

endpackage

`default_nettype wire

// ==== flist.f ====
design/sync_pkg.sv
design/sync_in_fifo.sv
design/metric_gate.sv
design/peak_detect.sv
design/out_credit_ctrl.sv
design/sync_detect_top.sv
verification/tb_clock_gen.sv
verification/sync_detect_asserts.sv
verification/tb_sync_detect.sv

// ==== verification/sync_detect_asserts.sv ====
`default_nettype none

module sync_detect_asserts #(
  parameter int OUT_CREDITS = 4
) (
  input logic              clk,
  input logic              i_arst_n,
  input logic              i_in_valid,
  input logic              i_out_valid,
  input logic              i_ds_credit,
  input sync_pkg::credit_t i_credit_cnt,
  input logic              i_fifo_full
);
  timeunit 1ns;
  timeprecision 100ps;

  // Credits still granted by downstream, counted from the port handshakes alone
  sync_pkg::credit_t granted;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      granted <= sync_pkg::credit_t'(OUT_CREDITS);
    end else begin
      granted <= granted - sync_pkg::credit_t'(i_out_valid)
                 + sync_pkg::credit_t'(i_ds_credit);
    end
  end

  // Returned credits never lift the count above the downstream grant
  credit_ceiling: assert property (
    @(posedge clk) disable iff (!i_arst_n)
    i_credit_cnt <= sync_pkg::credit_t'(OUT_CREDITS)
  ) else $error("output credit count %0d above %0d", i_credit_cnt, OUT_CREDITS);

  send_needs_credit: assert property (
    @(posedge clk) disable iff (!i_arst_n)
    i_out_valid |-> (granted != '0)
  ) else $error("o_valid asserted with no output credit");

  // Upstream is bounded by its credits, so a full buffer never sees a write
  no_write_when_full: assert property (
    @(posedge clk) disable iff (!i_arst_n)
    i_in_valid |-> !i_fifo_full
  ) else $error("i_valid arrived while the input buffer was full");

endmodule

bind sync_detect_top sync_detect_asserts #(
  .OUT_CREDITS (OUT_CREDITS)
) u_asserts (
  .clk          (clk),
  .i_arst_n     (i_arst_n),
  .i_in_valid   (i_valid),
  .i_out_valid  (o_valid),
  .i_ds_credit  (i_credit),
  .i_credit_cnt (u_out_credit.credit_cnt),
  .i_fifo_full  (u_in_fifo.full)
);

`default_nettype wire

// ==== verification/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS = 8
) (
  output logic clk
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

endmodule

`default_nettype wire

// ==== verification/tb_sync_detect.sv ====
`default_nettype none

module tb_sync_detect;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int FIFO_DEPTH      = 8;
  localparam int AVG_WINDOW_LOG2 = 3;
  localparam int NRX_TRIG        = 16;
  localparam int OUT_CREDITS     = 4;
  localparam int WIN             = 1 << AVG_WINDOW_LOG2;
  localparam int FRAME_COUNT     = 16;
  localparam int WAIT_LIMIT      = 2000;

  logic              clk;
  logic              arst_n;
  logic              in_valid;
  sync_pkg::metric_t in_metric;
  logic              in_last;
  logic              credit_ret;
  logic              out_valid;
  sync_pkg::metric_t out_metric;
  logic              out_last;
  logic              out_gate;
  logic              out_peak;
  logic              ds_credit;

  logic [31:0]       lfsr_state = 32'h14863df3;
  sync_pkg::credit_t up_credits = sync_pkg::credit_t'(FIFO_DEPTH);
  int                pending_credits = 0;
  logic              hold_credits = 1'b0;
  int                samples_sent = 0;
  int                returns_seen = 0;
  int                sends_seen = 0;
  int                peaks_seen = 0;
  int                metric_errs = 0;
  int                flag_errs = 0;
  int                count_errs = 0;
  int                other_errs = 0;

  // Expected outputs in send order
  sync_pkg::metric_t exp_metric_q [$];
  logic              exp_last_q [$];
  logic              exp_gate_q [$];
  logic              exp_peak_q [$];

  // Reference model state
  int                  win_q [WIN];
  int                  win_sum = 0;
  sync_pkg::pk_state_e pk_state = sync_pkg::PK_INIT;
  sync_pkg::metric_t   pk_max = '0;
  sync_pkg::hist_t     pk_hist = '0;
  int                  pk_hold = 0;
  logic                pk_flag = 1'b0;

  tb_clock_gen #(.PERIOD_NS (8)) u_clk (.clk (clk));

  sync_detect_top #(
    .FIFO_DEPTH      (FIFO_DEPTH),
    .AVG_WINDOW_LOG2 (AVG_WINDOW_LOG2),
    .NRX_TRIG        (NRX_TRIG),
    .OUT_CREDITS     (OUT_CREDITS)
  ) u_dut (
    .clk             (clk),
    .i_arst_n        (arst_n),
    .i_valid         (in_valid),
    .i_metric        (in_metric),
    .i_last          (in_last),
    .o_credit_return (credit_ret),
    .o_valid         (out_valid),
    .o_metric        (out_metric),
    .o_last          (out_last),
    .o_gate          (out_gate),
    .o_peak          (out_peak),
    .i_credit        (ds_credit)
  );

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  function automatic int take_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = (v << 1) | int'(lfsr_state[0]);
    end
    return v;
  endfunction

  task automatic check_metric(input string name, input sync_pkg::metric_t exp,
                              input sync_pkg::metric_t act);
    if (act !== exp) begin
      metric_errs++;
      $display("CHECK FAILED at %0t: %s expected %0d, got %0d", $time, name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      flag_errs++;
      $display("CHECK FAILED at %0t: %s expected %b, got %b", $time, name, exp, act);
    end
  endtask

  task automatic check_credit(input string name, input sync_pkg::credit_t exp,
                              input sync_pkg::credit_t act);
    if (act !== exp) begin
      count_errs++;
      $display("CHECK FAILED at %0t: %s expected %0d, got %0d", $time, name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      count_errs++;
      $display("CHECK FAILED at %0t: %s expected %0d, got %0d", $time, name, exp, act);
    end
  endtask

  task automatic finish_run();
    int total;
    total = metric_errs + flag_errs + count_errs + other_errs;
    $display("Samples %0d, peak flags %0d", sends_seen, peaks_seen);
    $display("Errors: metric %0d, flag %0d, count %0d, other %0d",
             metric_errs, flag_errs, count_errs, other_errs);
    if (total == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  endtask

  task automatic give_up(input string what);
    other_errs++;
    $display("ERROR at %0t: timed out waiting for %s", $time, what);
    finish_run();
  endtask

  // Each step lands 1 ns after the edge and may hand one credit back downstream
  task automatic next_cycle();
    @(posedge clk);
    #1;
    if (!hold_credits && pending_credits > 0 && take_bits(2) != 0) begin
      ds_credit = 1'b1;
      pending_credits--;
    end else begin
      ds_credit = 1'b0;
    end
  endtask

  task automatic model_sample(input sync_pkg::metric_t m, input logic last);
    int   thr;
    logic gate;
    thr  = win_sum >> (AVG_WINDOW_LOG2 - 1);
    gate = (int'(m) >= thr);
    if (!gate) begin
      pk_state = sync_pkg::PK_INIT;
      pk_flag  = 1'b0;
    end else if (pk_state == sync_pkg::PK_INIT) begin
      pk_max   = m;
      pk_hist  = '0;
      pk_hold  = 0;
      pk_flag  = 1'b0;
      pk_state = sync_pkg::PK_TRIG;
    end else if (pk_state == sync_pkg::PK_TRIG) begin
      if (pk_hold >= NRX_TRIG) begin
        pk_state = sync_pkg::PK_WAIT;
        pk_flag  = (pk_hist == 8'hff);
      end else if (m == pk_max) begin
        pk_hold = 0;
      end else if (m > pk_max) begin
        pk_max  = m;
        pk_hist = {pk_hist[6:0], 1'b1};
        pk_hold = 0;
      end else begin
        pk_hold++;
      end
    end else if (pk_state == sync_pkg::PK_WAIT) begin
      pk_state = sync_pkg::PK_IDLE;
    end else begin
      pk_state = sync_pkg::PK_INIT;
    end
    exp_metric_q.push_back(m);
    exp_last_q.push_back(last);
    exp_gate_q.push_back(gate);
    exp_peak_q.push_back(pk_flag);
    if (last) begin
      for (int i = 0; i < WIN; i++) begin
        win_q[i] = 0;
      end
      win_sum  = 0;
      pk_state = sync_pkg::PK_INIT;
      pk_max   = '0;
      pk_hist  = '0;
      pk_hold  = 0;
      pk_flag  = 1'b0;
    end else begin
      win_sum = win_sum - win_q[WIN-1] + int'(m);
      for (int i = WIN - 1; i > 0; i--) begin
        win_q[i] = win_q[i-1];
      end
      win_q[0] = int'(m);
    end
  endtask

  task automatic send_sample(input sync_pkg::metric_t m, input logic last);
    int waited;
    waited = 0;
    while (up_credits == 0) begin
      if (waited >= WAIT_LIMIT) begin
        give_up("an upstream credit");
      end else begin
        next_cycle();
        waited++;
      end
    end
    in_valid  = 1'b1;
    in_metric = m;
    in_last   = last;
    up_credits--;
    samples_sent++;
    model_sample(m, last);
    next_cycle();
    in_valid = 1'b0;
    in_last  = 1'b0;
  endtask

  // Noise, a ramp of nine or more rises, a hold below the top, then noise
  task automatic send_frame();
    sync_pkg::metric_t frame_q [$];
    sync_pkg::metric_t level;
    sync_pkg::metric_t top;
    int                len;
    int                cut;
    len = 4 + take_bits(3);
    for (int i = 0; i < len; i++) begin
      frame_q.push_back(sync_pkg::metric_t'(take_bits(4)));
    end
    len   = 9 + take_bits(2);
    level = sync_pkg::metric_t'(32 + take_bits(5));
    for (int i = 0; i < len; i++) begin
      frame_q.push_back(level);
      level = level + sync_pkg::metric_t'(16 + take_bits(5));
    end
    top = frame_q[frame_q.size()-1];
    len = NRX_TRIG + take_bits(3);
    for (int i = 0; i < len; i++) begin
      frame_q.push_back(top - sync_pkg::metric_t'(1 + take_bits(4)));
    end
    len = 2 + take_bits(3);
    for (int i = 0; i < len; i++) begin
      frame_q.push_back(sync_pkg::metric_t'(take_bits(4)));
    end
    if (take_bits(2) == 0) begin
      cut = 1 + (take_bits(6) % frame_q.size());
      while (frame_q.size() > cut) begin
        frame_q.delete(frame_q.size() - 1);
      end
    end
    for (int i = 0; i < frame_q.size(); i++) begin
      send_sample(frame_q[i], i == frame_q.size() - 1);
      if (take_bits(2) == 0) begin
        next_cycle();
      end
    end
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while (exp_metric_q.size() != 0 || pending_credits != 0) begin
      if (waited >= WAIT_LIMIT) begin
        give_up("the pipeline to drain");
      end else begin
        next_cycle();
        waited++;
      end
    end
  endtask

  task automatic wait_sends(input int target);
    int waited;
    waited = 0;
    while (sends_seen < target) begin
      if (waited >= WAIT_LIMIT) begin
        give_up("outputs while credits were withheld");
      end else begin
        next_cycle();
        waited++;
      end
    end
  endtask

  // Outputs are stable at the falling edge
  always @(negedge clk) begin
    if (arst_n) begin
      if (credit_ret) begin
        up_credits++;
        returns_seen++;
      end
      if (out_valid) begin
        sends_seen++;
        pending_credits++;
        if (exp_metric_q.size() == 0) begin
          other_errs++;
          $display("ERROR at %0t: output sample appeared with none expected", $time);
        end else begin
          check_metric("o_metric", exp_metric_q.pop_front(), out_metric);
          check_flag("o_last", exp_last_q.pop_front(), out_last);
          check_flag("o_gate", exp_gate_q.pop_front(), out_gate);
          check_flag("o_peak", exp_peak_q.pop_front(), out_peak);
          if (out_peak) begin
            peaks_seen++;
          end
        end
      end
    end
  end

  initial begin
    int base;
    arst_n    = 1'b0;
    in_valid  = 1'b0;
    in_metric = '0;
    in_last   = 1'b0;
    ds_credit = 1'b0;
    for (int i = 0; i < WIN; i++) begin
      win_q[i] = 0;
    end
    @(posedge clk);
    @(negedge clk);
    check_flag("o_valid in reset", 1'b0, out_valid);
    check_flag("o_credit_return in reset", 1'b0, credit_ret);
    @(posedge clk);
    #1;
    arst_n = 1'b1;
    @(negedge clk);
    check_flag("o_valid after reset", 1'b0, out_valid);
    check_flag("o_credit_return after reset", 1'b0, credit_ret);
    next_cycle();

    for (int f = 0; f < FRAME_COUNT; f++) begin
      send_frame();
    end
    wait_drained();

    // Downstream stops granting, so exactly the held credits may leave
    hold_credits = 1'b1;
    base = sends_seen;
    for (int i = 0; i < 10; i++) begin
      send_sample(sync_pkg::metric_t'(take_bits(4)), i == 9);
    end
    wait_sends(base + OUT_CREDITS);
    repeat (16) next_cycle();
    check_count("outputs while credits withheld", OUT_CREDITS, sends_seen - base);
    hold_credits = 1'b0;
    wait_drained();

    for (int f = 0; f < 4; f++) begin
      send_frame();
    end
    wait_drained();
    check_count("credit returns", samples_sent, returns_seen);
    check_count("samples out", samples_sent, sends_seen);
    check_credit("upstream credits", sync_pkg::credit_t'(FIFO_DEPTH), up_credits);
    finish_run();
  end

endmodule

`default_nettype wire
